//--- all.f
src/LsuPkg.sv
src/DCachePkg.sv
src/SyncRam.sv
src/LoadAligner.sv
src/StoreMerger.sv
src/LineReplacer.sv
src/LoadStoreController.sv
src/LoadStoreUnit.sv
tb/LineMemoryModel.sv
tb/LoadStoreUnitTb.sv

//--- run.sh
#!/bin/sh
# Build and run the load/store unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module LoadStoreUnitTb -Mdir obj_dir -f all.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/VLoadStoreUnitTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" sim.log; then
    exit 0
fi
exit 1

//--- src/DCachePkg.sv
/*
 * Data cache geometry and array types.
 * Direct-mapped, 16 lines of 8 bytes over a 16-bit physical address.
 */
package DCachePkg;
    localparam int PADDR_WIDTH = 16;
    localparam int LINE_SIZE = 8;
    localparam int LINE_WIDTH = LINE_SIZE * 8;
    localparam int INDEX_WIDTH = 4;
    localparam int OFFSET_WIDTH = $clog2(LINE_SIZE);
    localparam int TAG_WIDTH = PADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
    localparam int MEM_ADDR_WIDTH = PADDR_WIDTH - OFFSET_WIDTH;

    typedef logic [PADDR_WIDTH-1:0] Paddr;
    typedef logic [TAG_WIDTH-1:0] CacheTag;
    typedef logic [INDEX_WIDTH-1:0] CacheIndex;
    typedef logic [OFFSET_WIDTH-1:0] LineOffset;
    typedef logic [LINE_WIDTH-1:0] CacheLine;
    typedef logic [LINE_SIZE-1:0] WriteMask;
    typedef logic [MEM_ADDR_WIDTH-1:0] MemAddr;

    typedef struct packed {
        logic valid;
        CacheTag tag;
    } TagEntry;

    typedef enum logic [1:0] {
        ReplaceCommand_None = 2'h0,
        ReplaceCommand_Refill = 2'h1,
        ReplaceCommand_WriteThrough = 2'h2,
        ReplaceCommand_Invalidate = 2'h3
    } ReplaceCommand;
endpackage

//--- src/LineReplacer.sv
/*
 * Cache line replacer.
 * Refills a line from memory, writes a line through to memory, or
 * sweeps the tag array invalid, over the request/grant memory port.
 */
`timescale 1ns/1ps

module LineReplacer
    import DCachePkg::*;
(
    input logic clk,
    input logic rst,
    input ReplaceCommand replaceCommand,
    input MemAddr lineAddr,
    output CacheIndex arrayIndex,
    output logic arrayWriteEnable,
    output logic arrayWriteValid,
    output CacheLine arrayWriteData,
    input CacheLine arrayReadData,
    output MemAddr memAddr,
    output logic memReadReq,
    input logic memReadGrant,
    input CacheLine memReadValue,
    output logic memWriteReq,
    input logic memWriteGrant,
    output CacheLine memWriteValue,
    output logic replaceDone
);
    typedef enum logic [2:0] {
        State_Idle,
        State_MemRead,
        State_ArrayWrite,
        State_ArrayRead,
        State_MemWrite,
        State_Sweep
    } State;

    State state;
    CacheIndex sweepIndex;
    CacheLine lineBuffer;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= State_Idle;
            sweepIndex <= '0;
        end
        else begin
            unique case (state)
                State_Idle: begin
                    unique case (replaceCommand)
                        ReplaceCommand_Refill:       state <= State_MemRead;
                        ReplaceCommand_WriteThrough: state <= State_ArrayRead;
                        ReplaceCommand_Invalidate:   state <= State_Sweep;
                        default:                     state <= State_Idle;
                    endcase
                end
                State_MemRead:    state <= memReadGrant ? State_ArrayWrite : State_MemRead;
                State_ArrayRead:  state <= State_MemWrite;
                State_MemWrite:   state <= memWriteGrant ? State_Idle : State_MemWrite;
                State_Sweep: begin
                    // Index wraps back to zero on the last entry
                    sweepIndex <= sweepIndex + 1'b1;
                    state <= (sweepIndex == '1) ? State_Idle : State_Sweep;
                end
                default:          state <= State_Idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == State_MemRead && memReadGrant) begin
            lineBuffer <= memReadValue;
        end
    end

    always_comb begin
        arrayIndex = (state == State_Sweep) ? sweepIndex : lineAddr[INDEX_WIDTH-1:0];
        arrayWriteEnable = (state == State_ArrayWrite) || (state == State_Sweep);
        arrayWriteValid = (state == State_ArrayWrite);
        arrayWriteData = lineBuffer;

        memAddr = lineAddr;
        memReadReq = (state == State_MemRead);
        memWriteReq = (state == State_MemWrite);
        // Data array keeps reading the same line while the write waits
        memWriteValue = arrayReadData;

        replaceDone = (state == State_ArrayWrite) ||
            (state == State_MemWrite && memWriteGrant) ||
            (state == State_Sweep && sweepIndex == '1);
    end
endmodule

//--- src/LoadAligner.sv
/*
 * Load data aligner.
 * Picks the accessed bytes out of a cache line and sign or zero
 * extends them to a full word according to the access size.
 */
`timescale 1ns/1ps

module LoadAligner
    import LsuPkg::*, DCachePkg::*;
(
    input CacheLine line,
    input LineOffset offset,
    input AccessSize accessSize,
    output Word value
);
    CacheLine shifted;

    always_comb begin
        shifted = line >> {offset, 3'b000};

        unique case (accessSize)
            AccessSize_Byte: begin
                value = {{(WORD_WIDTH - 8){shifted[7]}}, shifted[7:0]};
            end
            AccessSize_HalfWord: begin
                value = {{(WORD_WIDTH - 16){shifted[15]}}, shifted[15:0]};
            end
            AccessSize_UnsignedByte: begin
                value = {{(WORD_WIDTH - 8){1'b0}}, shifted[7:0]};
            end
            AccessSize_UnsignedHalfWord: begin
                value = {{(WORD_WIDTH - 16){1'b0}}, shifted[15:0]};
            end
            default: begin
                // Full word
                value = shifted[WORD_WIDTH-1:0];
            end
        endcase
    end
endmodule

//--- src/LoadStoreController.sv
/*
 * Load/store controller.
 * Main FSM of the unit: latches the request, checks the tag for a hit,
 * steers the tag and data arrays between its own accesses and the
 * line replacer, and produces done and result.
 */
`timescale 1ns/1ps

module LoadStoreController
    import LsuPkg::*, DCachePkg::*;
(
    input logic clk,
    input logic rst,
    input logic enable,
    input LsuCommand command,
    input AccessSize accessSize,
    input Paddr addr,
    input Word storeValue,
    output logic done,
    output Word result,
    output LineOffset reqOffset,
    output AccessSize reqAccessSize,
    output Word reqStoreValue,
    output CacheIndex tagIndex,
    output logic tagWriteEnable,
    output TagEntry tagWriteValue,
    input TagEntry tagReadValue,
    output CacheIndex dataIndex,
    output WriteMask dataWriteMask,
    output CacheLine dataWriteData,
    input CacheLine mergedData,
    input WriteMask mergedMask,
    input Word alignedValue,
    output ReplaceCommand replaceCommand,
    output MemAddr lineAddr,
    input CacheIndex arrayIndex,
    input logic arrayWriteEnable,
    input logic arrayWriteValid,
    input CacheLine arrayWriteData,
    input logic replaceDone
);
    typedef enum logic [2:0] {
        State_Idle,
        State_Load,
        State_Store,
        State_Refill,
        State_WriteThrough,
        State_Invalidate
    } State;

    State state;
    State nextState;
    Paddr regAddr;
    LsuCommand regCommand;
    Word oldWord;
    CacheIndex reqIndex;
    CacheTag reqTag;
    logic hit;
    logic replacerOwnsArrays;

    always_comb begin
        reqIndex = regAddr[OFFSET_WIDTH +: INDEX_WIDTH];
        reqTag = regAddr[PADDR_WIDTH-1 -: TAG_WIDTH];
        hit = tagReadValue.valid && (tagReadValue.tag == reqTag);
        lineAddr = regAddr[PADDR_WIDTH-1:OFFSET_WIDTH];
        reqOffset = regAddr[OFFSET_WIDTH-1:0];
    end

    always_comb begin
        unique case (state)
            State_Idle: begin
                if (!enable) begin
                    nextState = State_Idle;
                end
                else if (command == LsuCommand_Store) begin
                    nextState = State_Store;
                end
                else if (command == LsuCommand_Invalidate) begin
                    nextState = State_Invalidate;
                end
                else begin
                    // Loads and atomics read first
                    nextState = State_Load;
                end
            end
            State_Load: begin
                if (!hit) begin
                    nextState = State_Refill;
                end
                else begin
                    nextState = (regCommand == LsuCommand_AtomicMemOp) ? State_Store : State_Idle;
                end
            end
            State_Store:  nextState = hit ? State_WriteThrough : State_Refill;
            default:      nextState = replaceDone ? State_Idle : state;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= State_Idle;
        end
        else begin
            state <= nextState;
        end
    end

    always_ff @(posedge clk) begin
        if (state == State_Idle) begin
            regAddr <= addr;
            regCommand <= command;
            reqAccessSize <= accessSize;
            reqStoreValue <= storeValue;
        end
        if (state == State_Load) begin
            oldWord <= alignedValue;
        end
    end

    always_comb begin
        unique case (state)
            State_Refill:       replaceCommand = ReplaceCommand_Refill;
            State_WriteThrough: replaceCommand = ReplaceCommand_WriteThrough;
            State_Invalidate:   replaceCommand = ReplaceCommand_Invalidate;
            default:            replaceCommand = ReplaceCommand_None;
        endcase
    end

    always_comb begin
        replacerOwnsArrays = (state == State_Refill) || (state == State_Invalidate);

        // Idle looks up the incoming address so the read is ready next cycle
        tagIndex = (state == State_Idle) ? addr[OFFSET_WIDTH +: INDEX_WIDTH] : reqIndex;
        tagWriteEnable = 1'b0;
        tagWriteValue.valid = arrayWriteValid;
        tagWriteValue.tag = reqTag;
        if (replacerOwnsArrays) begin
            tagIndex = arrayIndex;
            tagWriteEnable = arrayWriteEnable;
        end

        dataIndex = tagIndex;
        dataWriteMask = '0;
        dataWriteData = mergedData;
        if (replacerOwnsArrays) begin
            dataWriteData = arrayWriteData;
            dataWriteMask = (state == State_Refill && arrayWriteEnable) ? '1 : '0;
        end
        else if (state == State_Store && hit) begin
            dataWriteMask = mergedMask;
        end
    end

    always_comb begin
        done = (state == State_Load && hit && regCommand == LsuCommand_Load) ||
            ((state == State_WriteThrough || state == State_Invalidate) && replaceDone);

        unique case (regCommand)
            LsuCommand_Load:        result = alignedValue;
            LsuCommand_AtomicMemOp: result = oldWord;
            default:                result = '0;
        endcase
    end
endmodule

//--- src/LoadStoreUnit.sv
/*
 * Data cache load/store unit.
 * Direct-mapped write-through cache with one tag RAM and eight byte-wide
 * data banks, a controller, a line replacer on the memory port, and the
 * load aligner and store merger helpers.
 */
`timescale 1ns/1ps

module LoadStoreUnit
    import LsuPkg::*, DCachePkg::*;
(
    input logic clk,
    input logic rst,
    input logic enable,
    input LsuCommand command,
    input AccessSize accessSize,
    input AtomicOp atomicOp,
    input Paddr addr,
    input Word storeValue,
    output logic done,
    output Word result,
    output MemAddr memAddr,
    output logic memReadReq,
    input logic memReadGrant,
    input CacheLine memReadValue,
    output logic memWriteReq,
    input logic memWriteGrant,
    output CacheLine memWriteValue
);
    LineOffset reqOffset;
    AccessSize reqAccessSize;
    Word reqStoreValue;
    Word alignedValue;
    CacheLine mergedData;
    WriteMask mergedMask;

    CacheIndex tagIndex;
    logic tagWriteEnable;
    TagEntry tagWriteValue;
    TagEntry tagReadValue;

    CacheIndex dataIndex;
    WriteMask dataWriteMask;
    CacheLine dataWriteData;
    CacheLine dataReadData;

    ReplaceCommand replaceCommand;
    MemAddr lineAddr;
    CacheIndex arrayIndex;
    logic arrayWriteEnable;
    logic arrayWriteValid;
    CacheLine arrayWriteData;
    logic replaceDone;

    LoadStoreController controller (
        .clk, .rst, .enable, .command, .accessSize, .addr, .storeValue,
        .done, .result, .reqOffset, .reqAccessSize, .reqStoreValue,
        .tagIndex, .tagWriteEnable, .tagWriteValue, .tagReadValue,
        .dataIndex, .dataWriteMask, .dataWriteData,
        .mergedData, .mergedMask, .alignedValue,
        .replaceCommand, .lineAddr, .arrayIndex, .arrayWriteEnable,
        .arrayWriteValid, .arrayWriteData, .replaceDone
    );

    LineReplacer replacer (
        .clk, .rst, .replaceCommand, .lineAddr, .arrayIndex, .arrayWriteEnable,
        .arrayWriteValid, .arrayWriteData, .arrayReadData(dataReadData),
        .memAddr, .memReadReq, .memReadGrant, .memReadValue,
        .memWriteReq, .memWriteGrant, .memWriteValue, .replaceDone
    );

    LoadAligner aligner (
        .line(dataReadData), .offset(reqOffset), .accessSize(reqAccessSize), .value(alignedValue)
    );

    StoreMerger merger (
        .command, .atomicOp, .accessSize(reqAccessSize), .offset(reqOffset),
        .storeValue(reqStoreValue), .memValue(alignedValue),
        .writeData(mergedData), .writeMask(mergedMask)
    );

    SyncRam #(.Payload(TagEntry), .DEPTH_WIDTH(INDEX_WIDTH)) tagRam (
        .clk, .rst, .index(tagIndex), .writeEnable(tagWriteEnable),
        .writeValue(tagWriteValue), .readValue(tagReadValue)
    );

    // One bank per byte lane, each written by its mask bit
    for (genvar i = 0; i < LINE_SIZE; i++) begin : gDataBank
        SyncRam #(.Payload(logic [7:0]), .DEPTH_WIDTH(INDEX_WIDTH)) dataBank (
            .clk, .rst, .index(dataIndex), .writeEnable(dataWriteMask[i]),
            .writeValue(dataWriteData[8*i +: 8]), .readValue(dataReadData[8*i +: 8])
        );
    end
endmodule

//--- src/LsuPkg.sv
/*
 * Load/store unit request types.
 * Commands, access sizes and atomic operations seen by the requester,
 * plus the data word width.
 */
package LsuPkg;
    localparam int WORD_WIDTH = 32;

    typedef logic [WORD_WIDTH-1:0] Word;

    typedef enum logic [1:0] {
        LsuCommand_Load = 2'h0,
        LsuCommand_Store = 2'h1,
        LsuCommand_AtomicMemOp = 2'h2,
        LsuCommand_Invalidate = 2'h3
    } LsuCommand;

    typedef enum logic [2:0] {
        AccessSize_Byte = 3'h0,
        AccessSize_HalfWord = 3'h1,
        AccessSize_Word = 3'h2,
        AccessSize_UnsignedByte = 3'h3,
        AccessSize_UnsignedHalfWord = 3'h4
    } AccessSize;

    typedef enum logic [3:0] {
        AtomicOp_Swap = 4'h0,
        AtomicOp_Add = 4'h1,
        AtomicOp_Xor = 4'h2,
        AtomicOp_And = 4'h3,
        AtomicOp_Or = 4'h4,
        AtomicOp_Min = 4'h5,
        AtomicOp_Max = 4'h6,
        AtomicOp_Minu = 4'h7,
        AtomicOp_Maxu = 4'h8
    } AtomicOp;
endpackage

//--- src/StoreMerger.sv
/*
 * Store data merger.
 * Runs the atomic ALU for read-modify-write commands, places the
 * store value into its byte lanes and builds the byte write mask.
 */
`timescale 1ns/1ps

module StoreMerger
    import LsuPkg::*, DCachePkg::*;
(
    input LsuCommand command,
    input AtomicOp atomicOp,
    input AccessSize accessSize,
    input LineOffset offset,
    input Word storeValue,
    input Word memValue,
    output CacheLine writeData,
    output WriteMask writeMask
);
    Word aluValue;
    Word placeValue;
    WriteMask sizeMask;

    always_comb begin
        unique case (atomicOp)
            AtomicOp_Add:  aluValue = storeValue + memValue;
            AtomicOp_Xor:  aluValue = storeValue ^ memValue;
            AtomicOp_And:  aluValue = storeValue & memValue;
            AtomicOp_Or:   aluValue = storeValue | memValue;
            AtomicOp_Min:  aluValue = ($signed(storeValue) < $signed(memValue)) ? storeValue : memValue;
            AtomicOp_Max:  aluValue = ($signed(storeValue) > $signed(memValue)) ? storeValue : memValue;
            AtomicOp_Minu: aluValue = (storeValue < memValue) ? storeValue : memValue;
            AtomicOp_Maxu: aluValue = (storeValue > memValue) ? storeValue : memValue;
            default:       aluValue = storeValue;
        endcase

        placeValue = (command == LsuCommand_AtomicMemOp) ? aluValue : storeValue;
        writeData = CacheLine'(placeValue) << {offset, 3'b000};

        if (accessSize inside {AccessSize_Byte, AccessSize_UnsignedByte}) begin
            sizeMask = 8'b0000_0001;
        end
        else if (accessSize inside {AccessSize_HalfWord, AccessSize_UnsignedHalfWord}) begin
            sizeMask = 8'b0000_0011;
        end
        else begin
            sizeMask = 8'b0000_1111;
        end

        writeMask = sizeMask << offset;
    end
endmodule

//--- src/SyncRam.sv
/*
 * Single-port RAM with registered read.
 * While reset is high, entries are cleared one per cycle, so a reset
 * lasting at least the depth in cycles leaves every entry zero.
 */
`timescale 1ns/1ps

module SyncRam #(
    parameter type Payload = logic [7:0],
    parameter int DEPTH_WIDTH = 4
) (
    input logic clk,
    input logic rst,
    input logic [DEPTH_WIDTH-1:0] index,
    input logic writeEnable,
    input Payload writeValue,
    output Payload readValue
);
    Payload entries [0:(2**DEPTH_WIDTH)-1];
    logic [DEPTH_WIDTH-1:0] clearIndex;

    always_ff @(posedge clk) begin
        if (rst) begin
            // Counter wraps, so any start point covers every entry
            entries[clearIndex] <= '0;
            clearIndex <= clearIndex + 1'b1;
        end
        else begin
            if (writeEnable) begin
                entries[index] <= writeValue;
            end
            clearIndex <= '0;
        end
        readValue <= entries[index];
    end
endmodule

//--- tb/LineMemoryModel.sv
/*
 * Line-wide memory model for the request/grant port.
 * Each request is granted after a programmable number of wait cycles.
 * Read data is valid in the grant cycle. Writes land at the grant.
 */
`timescale 1ns/1ps

module LineMemoryModel
    import DCachePkg::*;
(
    input logic clk,
    input logic rst,
    input logic [2:0] grantDelay,
    input MemAddr memAddr,
    input logic memReadReq,
    output logic memReadGrant,
    output CacheLine memReadValue,
    input logic memWriteReq,
    output logic memWriteGrant,
    input CacheLine memWriteValue
);
    CacheLine lines [0:(2**MEM_ADDR_WIDTH)-1];
    logic [2:0] waitCount;
    int readCount;
    int writeCount;
    MemAddr lastWriteAddr;
    CacheLine lastWriteLine;

    // Byte at address a holds a * 7 + 3
    initial begin
        for (int i = 0; i < 2**MEM_ADDR_WIDTH; i++) begin
            for (int b = 0; b < LINE_SIZE; b++) begin
                lines[i][8*b +: 8] = 8'((i * LINE_SIZE + b) * 7 + 3);
            end
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            memReadGrant <= 1'b0;
            memWriteGrant <= 1'b0;
            waitCount <= '0;
            readCount <= 0;
            writeCount <= 0;
        end
        else if (memReadGrant || memWriteGrant) begin
            // Request is still high in the grant cycle
            memReadGrant <= 1'b0;
            memWriteGrant <= 1'b0;
        end
        else if (memReadReq || memWriteReq) begin
            if (waitCount < grantDelay) begin
                waitCount <= waitCount + 3'd1;
            end
            else begin
                waitCount <= '0;
                if (memReadReq) begin
                    memReadGrant <= 1'b1;
                    memReadValue <= lines[memAddr];
                    readCount <= readCount + 1;
                end
                else begin
                    memWriteGrant <= 1'b1;
                    lines[memAddr] <= memWriteValue;
                    lastWriteAddr <= memAddr;
                    lastWriteLine <= memWriteValue;
                    writeCount <= writeCount + 1;
                end
            end
        end
    end
endmodule

//--- tb/LoadStoreUnitTb.sv
/*
 * Testbench for the load/store unit.
 * Directed tests for loads, stores, atomics, invalidate and memory
 * back-pressure, checked against a byte mirror of memory.
 */
`timescale 1ns/1ps

module LoadStoreUnitTb
    import LsuPkg::*, DCachePkg::*;
();
    localparam int REQUEST_TIMEOUT = 200;

    logic clk;
    logic rst;
    logic enable;
    LsuCommand command;
    AccessSize accessSize;
    AtomicOp atomicOp;
    Paddr addr;
    Word storeValue;
    logic done;
    Word result;
    MemAddr memAddr;
    logic memReadReq;
    logic memReadGrant;
    CacheLine memReadValue;
    logic memWriteReq;
    logic memWriteGrant;
    CacheLine memWriteValue;
    logic [2:0] grantDelay;

    logic [7:0] mirror [0:65535];
    int errors;
    int checks;

    LoadStoreUnit LoadStoreUnit_inst (
        .clk, .rst, .enable, .command, .accessSize, .atomicOp, .addr, .storeValue,
        .done, .result, .memAddr, .memReadReq, .memReadGrant, .memReadValue,
        .memWriteReq, .memWriteGrant, .memWriteValue
    );

    LineMemoryModel memModel (
        .clk, .rst, .grantDelay, .memAddr, .memReadReq, .memReadGrant, .memReadValue,
        .memWriteReq, .memWriteGrant, .memWriteValue
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int sizeBytes(AccessSize size);
        if (size inside {AccessSize_Byte, AccessSize_UnsignedByte}) begin
            return 1;
        end
        else if (size inside {AccessSize_HalfWord, AccessSize_UnsignedHalfWord}) begin
            return 2;
        end
        return 4;
    endfunction

    function automatic Word expectedLoad(Paddr a, AccessSize size);
        int base;
        Word raw;
        base = int'(a);
        raw = {mirror[base + 3], mirror[base + 2], mirror[base + 1], mirror[base]};
        case (size)
            AccessSize_Byte: return {{24{raw[7]}}, raw[7:0]};
            AccessSize_HalfWord: return {{16{raw[15]}}, raw[15:0]};
            AccessSize_UnsignedByte: return {24'h0, raw[7:0]};
            AccessSize_UnsignedHalfWord: return {16'h0, raw[15:0]};
            default: return raw;
        endcase
    endfunction

    function automatic void writeMirror(Paddr a, AccessSize size, Word value);
        for (int b = 0; b < sizeBytes(size); b++) begin
            mirror[int'(a) + b] = value[8*b +: 8];
        end
    endfunction

    function automatic CacheLine mirrorLine(Paddr a);
        int base;
        CacheLine line;
        base = int'(a) & ~7;
        for (int b = 0; b < LINE_SIZE; b++) begin
            line[8*b +: 8] = mirror[base + b];
        end
        return line;
    endfunction

    function automatic Word atomicResult(AtomicOp op, Word old, Word operand);
        case (op)
            AtomicOp_Add: return old + operand;
            AtomicOp_Xor: return old ^ operand;
            AtomicOp_And: return old & operand;
            AtomicOp_Or: return old | operand;
            AtomicOp_Min: return ($signed(operand) < $signed(old)) ? operand : old;
            AtomicOp_Max: return ($signed(operand) > $signed(old)) ? operand : old;
            AtomicOp_Minu: return (operand < old) ? operand : old;
            AtomicOp_Maxu: return (operand > old) ? operand : old;
            default: return operand;
        endcase
    endfunction

    task automatic checkWord(string name, Word expected, Word actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic checkLine(string name, CacheLine expected, CacheLine actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic expectTrue(logic condition, string what);
        checks++;
        if (!condition) begin
            errors++;
            $display("ERROR %s", what);
        end
    endtask

    task automatic abortRun(string why);
        errors++;
        $display("ERROR %s", why);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        $display("SOME TESTS FAILED");
        $finish;
    endtask

    // Holds the request until done, then drops enable
    task automatic issueRequest(LsuCommand cmd, AccessSize size, AtomicOp op, Paddr a,
            Word value, output Word res);
        int cycles;
        @(posedge clk);
        enable <= 1'b1;
        command <= cmd;
        accessSize <= size;
        atomicOp <= op;
        addr <= a;
        storeValue <= value;
        cycles = 0;
        @(negedge clk);
        while (!done && cycles < REQUEST_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!done) begin
            abortRun($sformatf("timeout, no done for %s request at %h", cmd.name(), a));
        end
        else begin
            res = result;
            @(posedge clk);
            enable <= 1'b0;
        end
    endtask

    task automatic checkLoad(Paddr a, AccessSize size);
        Word res;
        issueRequest(LsuCommand_Load, size, AtomicOp_Swap, a, '0, res);
        checkWord($sformatf("load %s at %h", size.name(), a), expectedLoad(a, size), res);
    endtask

    task automatic storeAndCheck(Paddr a, AccessSize size, Word value);
        Word res;
        int writesBefore;
        writesBefore = memModel.writeCount;
        issueRequest(LsuCommand_Store, size, AtomicOp_Swap, a, value, res);
        writeMirror(a, size, value);
        checkWord($sformatf("store result at %h", a), '0, res);
        expectTrue(memModel.writeCount == writesBefore + 1,
            $sformatf("store at %h did not give exactly one line write", a));
        checkWord("store line address", Word'(a >> 3), Word'(memModel.lastWriteAddr));
        checkLine($sformatf("store line at %h", a), mirrorLine(a), memModel.lastWriteLine);
        checkLoad(a, size);
    endtask

    task automatic testReset();
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            expectTrue(!done && !memReadReq && !memWriteReq,
                "done or a memory request is active while idle after reset");
        end
    endtask

    task automatic testLoads();
        Paddr bases [2];
        Paddr a;
        int readsBefore;
        bases[0] = 16'h1230;
        bases[1] = 16'h2c18;
        for (int l = 0; l < 2; l++) begin
            // First access misses and refills
            checkLoad(bases[l], AccessSize_Word);
            readsBefore = memModel.readCount;
            for (int off = 0; off < LINE_SIZE; off++) begin
                a = bases[l] + Paddr'(off);
                checkLoad(a, AccessSize_Byte);
                checkLoad(a, AccessSize_UnsignedByte);
                if (off % 2 == 0) begin
                    checkLoad(a, AccessSize_HalfWord);
                    checkLoad(a, AccessSize_UnsignedHalfWord);
                end
                if (off % 4 == 0) begin
                    checkLoad(a, AccessSize_Word);
                end
            end
            expectTrue(memModel.readCount == readsBefore,
                $sformatf("loads to cached line %h read memory again", bases[l]));
        end
    endtask

    task automatic testStores();
        storeAndCheck(16'h1233, AccessSize_Byte, 32'h0000_00a5);
        storeAndCheck(16'h1236, AccessSize_HalfWord, 32'h0000_c3d2);
        storeAndCheck(16'h1234, AccessSize_Word, 32'h8765_4321);
        // Uncached line, refilled before the store
        storeAndCheck(16'h3a58, AccessSize_Word, 32'hdead_beef);
        storeAndCheck(16'h3a5d, AccessSize_UnsignedByte, 32'h0000_007e);
        storeAndCheck(16'h3a5a, AccessSize_UnsignedHalfWord, 32'h0000_9abc);
    endtask

    task automatic testAtomics();
        Paddr a;
        AtomicOp op;
        Word operand;
        Word oldWord;
        Word res;
        for (int i = 0; i < 9; i++) begin
            a = Paddr'(16'h0500 + 4 * i);
            op = AtomicOp'(i);
            operand = $urandom();
            storeAndCheck(a, AccessSize_Word, $urandom());
            oldWord = expectedLoad(a, AccessSize_Word);
            issueRequest(LsuCommand_AtomicMemOp, AccessSize_Word, op, a, operand, res);
            checkWord($sformatf("%s old word at %h", op.name(), a), oldWord, res);
            writeMirror(a, AccessSize_Word, atomicResult(op, oldWord, operand));
            checkLoad(a, AccessSize_Word);
        end
    endtask

    task automatic testInvalidate();
        Word res;
        int readsBefore;
        checkLoad(16'h1234, AccessSize_Word);
        issueRequest(LsuCommand_Invalidate, AccessSize_Word, AtomicOp_Swap, '0, '0, res);
        checkWord("invalidate result", '0, res);
        readsBefore = memModel.readCount;
        checkLoad(16'h1234, AccessSize_Word);
        expectTrue(memModel.readCount == readsBefore + 1,
            "load after invalidate did not refill the line");
    endtask

    task automatic testBackPressure();
        AccessSize size;
        Paddr a;
        for (int i = 0; i < 60; i++) begin
            @(posedge clk);
            grantDelay <= 3'($urandom_range(5));
            size = AccessSize'($urandom_range(4));
            a = Paddr'($urandom_range(16'h01ff)) & ~Paddr'(sizeBytes(size) - 1);
            if ($urandom_range(1) == 0) begin
                checkLoad(a, size);
            end
            else begin
                storeAndCheck(a, size, $urandom());
            end
        end
        for (int la = 0; la < 64; la++) begin
            checkLine($sformatf("memory line %h", la), mirrorLine(Paddr'(la * 8)),
                memModel.lines[la]);
        end
        @(posedge clk);
        grantDelay <= '0;
    endtask

    initial begin
        void'($urandom(32'hc625d583));
        errors = 0;
        checks = 0;
        for (int a = 0; a < 65536; a++) begin
            mirror[a] = 8'(a * 7 + 3);
        end
        rst <= 1'b1;
        enable <= 1'b0;
        command <= LsuCommand_Load;
        accessSize <= AccessSize_Word;
        atomicOp <= AtomicOp_Swap;
        addr <= '0;
        storeValue <= '0;
        grantDelay <= '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        testReset();
        testLoads();
        testStores();
        testAtomics();
        testInvalidate();
        testBackPressure();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end
        else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end
endmodule
